//--- Makefile
.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert --timescale 1ns/1ps -f build.f --top-module tb_icmu

run: build
	./obj_dir/Vtb_icmu > sim.log 2>&1 || true
	cat sim.log
	@if grep -q "tests failed" sim.log; then echo "Simulation failed"; exit 1; fi
	@grep -q "all tests passed" sim.log

lint:
	verilator --lint-only -Wall --timing --timescale 1ns/1ps -f build.f --top-module icmu_top

clean:
	rm -rf obj_dir sim.log

//--- build.f
+incdir+testbench
hdl/icmu_pkg.sv
hdl/irq_capture.sv
hdl/multilevel_icmu.sv
hdl/icmu_regs.sv
hdl/icmu_top.sv
testbench/tb_icmu.sv

//--- hdl/icmu_pkg.sv
// Interrupt controller widths, register offsets and AXI4-Lite response codes
package icmu_pkg;

    // Source and priority widths
    localparam int num_irq     = 8;
    localparam int irq_id_w    = 3;
    localparam int level_w     = 2;
    localparam int prio_flat_w = num_irq * level_w;

    // Processor context word
    localparam int context_w = 32;

    // AXI4-Lite bus widths
    localparam int axi_addr_w = 8;
    localparam int axi_data_w = 32;

    // Register map, byte offsets
    localparam logic [axi_addr_w-1:0] reg_priority      = 8'h00;
    localparam logic [axi_addr_w-1:0] reg_enable        = 8'h04;
    localparam logic [axi_addr_w-1:0] reg_pending       = 8'h08;
    localparam logic [axi_addr_w-1:0] reg_status        = 8'h0C;
    localparam logic [axi_addr_w-1:0] reg_ack           = 8'h10;
    localparam logic [axi_addr_w-1:0] reg_saved_context = 8'h14;

    // Status word field positions
    localparam int status_active_bit = 0;
    localparam int status_number_lsb = 4;
    localparam int status_level_lsb  = 8;

    // AXI response codes
    localparam logic [1:0] resp_okay   = 2'b00;
    localparam logic [1:0] resp_slverr = 2'b10;

endpackage

//--- hdl/icmu_regs.sv
// AXI4-Lite slave with the priority, enable, status, acknowledge and context registers
`timescale 1ns/1ps

module icmu_regs (
    input  logic                             clock,
    input  logic                             resetn,

    // AXI4-Lite write address and data
    input  logic [icmu_pkg::axi_addr_w-1:0]  awaddr,
    input  logic                             awvalid,
    output logic                             awready,
    input  logic [icmu_pkg::axi_data_w-1:0]  wdata,
    input  logic                             wvalid,
    output logic                             wready,

    // AXI4-Lite write response
    output logic [1:0]                       bresp,
    output logic                             bvalid,
    input  logic                             bready,

    // AXI4-Lite read address and data
    input  logic [icmu_pkg::axi_addr_w-1:0]  araddr,
    input  logic                             arvalid,
    output logic                             arready,
    output logic [icmu_pkg::axi_data_w-1:0]  rdata,
    output logic [1:0]                       rresp,
    output logic                             rvalid,
    input  logic                             rready,

    // Controller state
    input  logic [icmu_pkg::num_irq-1:0]     pending,
    input  logic                             handle_active,
    input  logic [icmu_pkg::irq_id_w-1:0]    int_number,
    input  logic [icmu_pkg::level_w-1:0]     current_level,
    input  logic [icmu_pkg::context_w-1:0]   saved_context,

    // Configuration and acknowledge
    output logic [icmu_pkg::prio_flat_w-1:0] priority_level_flat,
    output logic [icmu_pkg::num_irq-1:0]     enable,
    output logic                             ack_done
);
    import icmu_pkg::*;

    logic                  wr_hs;
    logic                  rd_hs;
    logic                  wr_mapped;
    logic                  rd_mapped;
    logic [axi_data_w-1:0] rd_word;

    assign wr_hs = awvalid & awready & wvalid & wready;
    assign rd_hs = arvalid & arready;

    // Write address decode
    always_comb begin
        case (awaddr)
            reg_priority,
            reg_enable,
            reg_pending,
            reg_status,
            reg_ack,
            reg_saved_context: wr_mapped = 1'b1;
            default:           wr_mapped = 1'b0;
        endcase
    end

    // Read data mux, status is built from live state
    always_comb begin
        rd_word   = '0;
        rd_mapped = 1'b1;
        case (araddr)
            reg_priority: rd_word[prio_flat_w-1:0] = priority_level_flat;
            reg_enable:   rd_word[num_irq-1:0] = enable;
            reg_pending:  rd_word[num_irq-1:0] = pending;
            reg_status: begin
                rd_word[status_active_bit] = handle_active;
                rd_word[status_number_lsb +: irq_id_w] = int_number;
                rd_word[status_level_lsb +: level_w] = current_level;
            end
            reg_saved_context: rd_word[context_w-1:0] = saved_context;
            default:      rd_mapped = 1'b0;
        endcase
    end

    // Write channel, address and data accepted together
    always_ff @(posedge clock or negedge resetn) begin
        if (!resetn) begin
            awready <= 1'b0;
            wready  <= 1'b0;
            bvalid  <= 1'b0;
        end else begin
            awready <= awvalid & wvalid & ~bvalid & ~awready;
            wready  <= awvalid & wvalid & ~bvalid & ~awready;
            if (wr_hs) begin
                bvalid <= 1'b1;
            end else if (bvalid && bready) begin
                bvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (wr_hs) begin
            bresp <= wr_mapped ? resp_okay : resp_slverr;
        end
    end

    // Writable registers and the acknowledge pulse
    always_ff @(posedge clock or negedge resetn) begin
        if (!resetn) begin
            priority_level_flat <= '0;
            enable              <= '0;
            ack_done            <= 1'b0;
        end else begin
            ack_done <= wr_hs && (awaddr == reg_ack);
            if (wr_hs && awaddr == reg_priority) begin
                priority_level_flat <= wdata[prio_flat_w-1:0];
            end
            if (wr_hs && awaddr == reg_enable) begin
                enable <= wdata[num_irq-1:0];
            end
        end
    end

    // Read channel
    always_ff @(posedge clock or negedge resetn) begin
        if (!resetn) begin
            arready <= 1'b0;
            rvalid  <= 1'b0;
        end else begin
            arready <= arvalid & ~rvalid & ~arready;
            if (rd_hs) begin
                rvalid <= 1'b1;
            end else if (rvalid && rready) begin
                rvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (rd_hs) begin
            rdata <= rd_word;
            rresp <= rd_mapped ? resp_okay : resp_slverr;
        end
    end

endmodule

//--- hdl/icmu_top.sv
// Interrupt controller top level joining register file, capture and arbitration
`timescale 1ns/1ps

module icmu_top #(
    parameter int sync_stages = 2
) (
    input  logic                            clock,
    input  logic                            resetn,
    input  logic [icmu_pkg::num_irq-1:0]    interrupts,
    input  logic [icmu_pkg::context_w-1:0]  current_context,
    output logic                            irq,

    // AXI4-Lite slave
    input  logic [icmu_pkg::axi_addr_w-1:0] awaddr,
    input  logic                            awvalid,
    output logic                            awready,
    input  logic [icmu_pkg::axi_data_w-1:0] wdata,
    input  logic                            wvalid,
    output logic                            wready,
    output logic [1:0]                      bresp,
    output logic                            bvalid,
    input  logic                            bready,
    input  logic [icmu_pkg::axi_addr_w-1:0] araddr,
    input  logic                            arvalid,
    output logic                            arready,
    output logic [icmu_pkg::axi_data_w-1:0] rdata,
    output logic [1:0]                      rresp,
    output logic                            rvalid,
    input  logic                            rready
);
    import icmu_pkg::*;

    logic [prio_flat_w-1:0] priority_level_flat;
    logic [num_irq-1:0]     enable;
    logic                   ack_done;
    logic [num_irq-1:0]     pending;
    logic [num_irq-1:0]     requests;
    logic [irq_id_w-1:0]    int_number;
    logic [level_w-1:0]     current_level;
    logic                   handle_active;
    logic                   retire;
    logic [context_w-1:0]   saved_context;

    icmu_regs u_regs (
        .clock               (clock),
        .resetn              (resetn),
        .awaddr              (awaddr),
        .awvalid             (awvalid),
        .awready             (awready),
        .wdata               (wdata),
        .wvalid              (wvalid),
        .wready              (wready),
        .bresp               (bresp),
        .bvalid              (bvalid),
        .bready              (bready),
        .araddr              (araddr),
        .arvalid             (arvalid),
        .arready             (arready),
        .rdata               (rdata),
        .rresp               (rresp),
        .rvalid              (rvalid),
        .rready              (rready),
        .pending             (pending),
        .handle_active       (handle_active),
        .int_number          (int_number),
        .current_level       (current_level),
        .saved_context       (saved_context),
        .priority_level_flat (priority_level_flat),
        .enable              (enable),
        .ack_done            (ack_done)
    );

    irq_capture #(
        .sync_stages (sync_stages)
    ) u_capture (
        .clock      (clock),
        .resetn     (resetn),
        .interrupts (interrupts),
        .enable     (enable),
        .retire     (retire),
        .int_number (int_number),
        .pending    (pending),
        .requests   (requests)
    );

    multilevel_icmu u_arbiter (
        .clock               (clock),
        .resetn              (resetn),
        .requests            (requests),
        .priority_level_flat (priority_level_flat),
        .ack_done            (ack_done),
        .current_context     (current_context),
        .int_number          (int_number),
        .current_level       (current_level),
        .handle_active       (handle_active),
        .retire              (retire),
        .saved_context       (saved_context)
    );

    // Processor sees the handler-active state directly
    assign irq = handle_active;

endmodule

//--- hdl/irq_capture.sv
// Interrupt line synchronizer, rising-edge detector, pending latch and enable gate
`timescale 1ns/1ps

module irq_capture #(
    parameter int sync_stages = 2
) (
    input  logic                          clock,
    input  logic                          resetn,
    input  logic [icmu_pkg::num_irq-1:0]  interrupts,
    input  logic [icmu_pkg::num_irq-1:0]  enable,
    input  logic                          retire,
    input  logic [icmu_pkg::irq_id_w-1:0] int_number,
    output logic [icmu_pkg::num_irq-1:0]  pending,
    output logic [icmu_pkg::num_irq-1:0]  requests
);
    import icmu_pkg::*;

    // Synchronizer chain, one word per stage
    logic [num_irq-1:0] sync_q [sync_stages];
    logic [num_irq-1:0] sync_prev;
    logic [num_irq-1:0] rise;
    logic [num_irq-1:0] clear_mask;

    assign rise = sync_q[sync_stages-1] & ~sync_prev;

    // Served source is cleared one cycle after retire
    always_comb begin
        clear_mask = '0;
        if (retire) begin
            clear_mask[int_number] = 1'b1;
        end
    end

    always_ff @(posedge clock or negedge resetn) begin
        if (!resetn) begin
            for (int s = 0; s < sync_stages; s++) begin
                sync_q[s] <= '0;
            end
            sync_prev <= '0;
            pending   <= '0;
        end else begin
            sync_q[0] <= interrupts;
            for (int s = 1; s < sync_stages; s++) begin
                sync_q[s] <= sync_q[s-1];
            end
            sync_prev <= sync_q[sync_stages-1];
            // A new edge beats a retire of the same bit
            pending   <= (pending & ~clear_mask) | rise;
        end
    end

    // Disabled sources stay pending but are not offered for service
    assign requests = pending & enable;

endmodule

//--- hdl/multilevel_icmu.sv
// Priority-level masking, arbitration, handler state and context save
`timescale 1ns/1ps

module multilevel_icmu (
    input  logic                           clock,
    input  logic                           resetn,
    input  logic [icmu_pkg::num_irq-1:0]   requests,
    input  logic [icmu_pkg::prio_flat_w-1:0] priority_level_flat,
    input  logic                           ack_done,
    input  logic [icmu_pkg::context_w-1:0] current_context,
    output logic [icmu_pkg::irq_id_w-1:0]  int_number,
    output logic [icmu_pkg::level_w-1:0]   current_level,
    output logic                           handle_active,
    output logic                           retire,
    output logic [icmu_pkg::context_w-1:0] saved_context
);
    import icmu_pkg::*;

    localparam int num_levels = 1 << level_w;

    logic [num_levels-1:0][num_irq-1:0] level_mask;
    logic [num_levels-1:0][num_irq-1:0] level_mask_r;
    logic [num_irq-1:0]                 requests_r;
    logic [level_w-1:0]                 sel_level;
    logic [irq_id_w-1:0]                sel_number;
    logic                               any_request;
    // Holds off arbitration until the retired bit has left requests_r
    logic                               settle;

    // Lowest set index wins
    function automatic logic [irq_id_w-1:0] find_first_set(input logic [num_irq-1:0] bits);
        logic [irq_id_w-1:0] result;
        result = '0;
        for (int i = num_irq - 1; i >= 0; i--) begin
            if (bits[i]) begin
                result = irq_id_w'(i);
            end
        end
        return result;
    endfunction

    // One mask per level from the packed priorities
    always_comb begin
        level_mask = '0;
        for (int i = 0; i < num_irq; i++) begin
            level_mask[priority_level_flat[i*level_w +: level_w]][i] = 1'b1;
        end
    end

    // Step one picks the highest non-empty level, step two the source within it
    always_comb begin
        sel_level = '0;
        for (int l = 0; l < num_levels; l++) begin
            if (|(requests_r & level_mask_r[l])) begin
                sel_level = level_w'(l);
            end
        end
        sel_number = find_first_set(requests_r & level_mask_r[sel_level]);
    end

    assign any_request = |requests_r;

    always_ff @(posedge clock or negedge resetn) begin
        if (!resetn) begin
            requests_r    <= '0;
            level_mask_r  <= '0;
            int_number    <= '0;
            current_level <= '0;
            handle_active <= 1'b0;
            retire        <= 1'b0;
            settle        <= 1'b0;
            saved_context <= '0;
        end else begin
            requests_r   <= requests;
            level_mask_r <= level_mask;
            retire       <= 1'b0;
            settle       <= retire;

            if (!handle_active && !retire && !settle && any_request) begin
                int_number    <= sel_number;
                current_level <= sel_level;
                handle_active <= 1'b1;
                saved_context <= current_context;
            end else if (handle_active && ack_done) begin
                handle_active <= 1'b0;
                retire        <= 1'b1;
            end
        end
    end

endmodule

//--- testbench/tb_axil_tasks.svh
// AXI4-Lite master write and read tasks with a clock step helper
`ifndef TB_AXIL_TASKS_SVH
`define TB_AXIL_TASKS_SVH

// Advance to just after the next rising edge, where inputs are changed
task automatic step_cycle();
    @(posedge clock);
    #1;
endtask

// Address and data go out together, then the response is taken with bready
task automatic write_word(input logic [axi_addr_w-1:0] addr, input logic [axi_data_w-1:0] data,
                          output logic [1:0] resp);
    step_cycle();
    awaddr  = addr;
    awvalid = 1'b1;
    wdata   = data;
    wvalid  = 1'b1;
    while (!(awready && wready)) step_cycle();
    // Handshake completes on the next edge
    step_cycle();
    awvalid = 1'b0;
    wvalid  = 1'b0;
    bready  = 1'b1;
    while (!bvalid) step_cycle();
    resp = bresp;
    step_cycle();
    bready = 1'b0;
endtask

task automatic read_word(input logic [axi_addr_w-1:0] addr, output logic [axi_data_w-1:0] data,
                         output logic [1:0] resp);
    step_cycle();
    araddr  = addr;
    arvalid = 1'b1;
    while (!arready) step_cycle();
    step_cycle();
    arvalid = 1'b0;
    rready  = 1'b1;
    while (!rvalid) step_cycle();
    data = rdata;
    resp = rresp;
    step_cycle();
    rready = 1'b0;
endtask

`endif

//--- testbench/tb_icmu.sv
// Interrupt controller testbench with reference model, ordered service checks and report
`timescale 1ns/1ps

module tb_icmu;
    import icmu_pkg::*;

    // About 70 served handlers at under 40 cycles each, plus setup and margin
    localparam int max_cycles     = 4000;
    localparam int irq_wait_limit = 32;

    logic                  clock;
    logic                  resetn;
    logic [num_irq-1:0]    interrupts;
    logic [context_w-1:0]  current_context;
    logic                  irq;
    logic [axi_addr_w-1:0] awaddr;
    logic                  awvalid;
    logic                  awready;
    logic [axi_data_w-1:0] wdata;
    logic                  wvalid;
    logic                  wready;
    logic [1:0]            bresp;
    logic                  bvalid;
    logic                  bready;
    logic [axi_addr_w-1:0] araddr;
    logic                  arvalid;
    logic                  arready;
    logic [axi_data_w-1:0] rdata;
    logic [1:0]            rresp;
    logic                  rvalid;
    logic                  rready;

    // Reference model of the controller state
    logic [level_w-1:0] prio_model [num_irq];
    logic [num_irq-1:0] enable_model;
    logic [num_irq-1:0] pending_model;

    int         error_count;
    int         test_start_errors;
    int         tests_passed;
    int         tests_failed;
    int         cycle_count;
    int         seed;
    logic [1:0] resp;

    icmu_top #(.sync_stages(2)) i_dut (.*);

    `include "tb_axil_tasks.svh"

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    always @(posedge clock) begin
        cycle_count++;
        if (cycle_count >= max_cycles) begin
            $display("Timeout after %0d cycles, a handshake or irq never arrived", cycle_count);
            $display("tests failed");
            $finish;
        end
    end

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        assert (actual === expected) else begin
            $display("ERR %s: got 0x%08h, expected 0x%08h", name, actual, expected);
            error_count++;
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        assert (cond) else begin
            $display("Check failed: %s", what);
            error_count++;
        end
    endtask

    task automatic end_test(input string name);
        if (error_count == test_start_errors) begin
            $display("Test %s: PASS", name);
            tests_passed++;
        end else begin
            $display("Test %s: FAIL with %0d errors", name, error_count - test_start_errors);
            tests_failed++;
        end
        test_start_errors = error_count;
    endtask

    task automatic expect_reg(input logic [axi_addr_w-1:0] addr, input logic [31:0] expected,
                              input string name);
        logic [31:0] data;
        logic [1:0]  rsp;
        read_word(addr, data, rsp);
        check_value({name, " rresp"}, {30'd0, rsp}, {30'd0, resp_okay});
        check_value(name, data, expected);
    endtask

    // Active in bit 0, number in bits 6 to 4, level in bits 9 to 8
    function automatic logic [31:0] status_word(input logic [2:0] num, input logic [1:0] lvl);
        return {22'd0, lvl, 1'b0, num, 3'd0, 1'b1};
    endfunction

    // Priorities and enable mask go to the DUT and the model together
    task automatic load_config(input logic [prio_flat_w-1:0] flat);
        for (int i = 0; i < num_irq; i++) begin
            prio_model[i] = flat[i*level_w +: level_w];
        end
        write_word(reg_priority, {16'd0, flat}, resp);
        check_value("bresp", {30'd0, resp}, {30'd0, resp_okay});
        write_word(reg_enable, {24'd0, enable_model}, resp);
        check_value("bresp", {30'd0, resp}, {30'd0, resp_okay});
    endtask

    // Two cycles high so the synchronizer sees the rising edge
    task automatic pulse_lines(input logic [num_irq-1:0] mask);
        step_cycle();
        interrupts = mask;
        step_cycle();
        step_cycle();
        interrupts = '0;
        pending_model = pending_model | mask;
    endtask

    task automatic wait_for_irq(input logic level);
        int waited;
        waited = 0;
        while (irq !== level && waited < irq_wait_limit) begin
            step_cycle();
            waited++;
        end
        check_true(irq === level,
                   $sformatf("irq did not reach %0d within %0d cycles", level, irq_wait_limit));
    endtask

    // Highest level first, then the lowest index among enabled pending sources
    task automatic expected_winner(output logic [irq_id_w-1:0] num,
                                   output logic [level_w-1:0] lvl);
        logic found;
        found = 1'b0;
        num = '0;
        lvl = '0;
        for (int l = 3; l >= 0; l--) begin
            for (int i = 0; i < num_irq; i++) begin
                if (!found && pending_model[i] && enable_model[i] && int'(prio_model[i]) == l) begin
                    found = 1'b1;
                    num = irq_id_w'(i);
                    lvl = level_w'(l);
                end
            end
        end
    endtask

    // One handler checked against the model and then acknowledged
    task automatic serve_next();
        logic [irq_id_w-1:0]  num;
        logic [level_w-1:0]   lvl;
        logic [context_w-1:0] held_context;
        expected_winner(num, lvl);
        wait_for_irq(1'b1);
        // Saved copy keeps the value from when the handler was taken
        held_context    = current_context;
        current_context = ~held_context;
        expect_reg(reg_status, status_word(num, lvl), "status");
        expect_reg(reg_saved_context, held_context, "saved_context");
        write_word(reg_ack, 32'd0, resp);
        check_value("bresp", {30'd0, resp}, {30'd0, resp_okay});
        wait_for_irq(1'b0);
        pending_model[num] = 1'b0;
    endtask

    initial begin
        logic [31:0]        rnd;
        logic [num_irq-1:0] mask;

        resetn          = 1'b0;
        interrupts      = '0;
        current_context = '0;
        awaddr          = '0;
        awvalid         = 1'b0;
        wdata           = '0;
        wvalid          = 1'b0;
        bready          = 1'b0;
        araddr          = '0;
        arvalid         = 1'b0;
        rready          = 1'b0;
        enable_model    = '0;
        pending_model   = '0;
        seed            = 60;
        repeat (4) @(posedge clock);
        #1;
        resetn = 1'b1;

        check_true(irq === 1'b0, "irq high after reset");
        expect_reg(reg_priority, 32'd0, "priority");
        expect_reg(reg_enable, 32'd0, "enable");
        expect_reg(reg_pending, 32'd0, "pending");
        expect_reg(reg_status, 32'd0, "status");
        expect_reg(reg_saved_context, 32'd0, "saved_context");
        end_test("reset");

        write_word(reg_priority, 32'hFFFF_A5C3, resp);
        expect_reg(reg_priority, 32'h0000_A5C3, "priority");
        write_word(reg_enable, 32'h0000_015A, resp);
        expect_reg(reg_enable, 32'h0000_005A, "enable");
        read_word(8'h18, rnd, resp);
        check_value("rresp", {30'd0, resp}, {30'd0, resp_slverr});
        check_value("rdata", rnd, 32'd0);
        write_word(reg_pending, 32'h0000_00FF, resp);
        check_value("bresp", {30'd0, resp}, {30'd0, resp_okay});
        expect_reg(reg_pending, 32'd0, "pending");
        end_test("register_access");

        // Source 3 at level 2
        enable_model    = '1;
        current_context = 32'hC0DE_1234;
        load_config(16'h0080);
        pulse_lines(8'h08);
        wait_for_irq(1'b1);
        expect_reg(reg_pending, 32'h0000_0008, "pending");
        serve_next();
        expect_reg(reg_pending, 32'd0, "pending");
        end_test("single_interrupt");

        // Levels by source 7..0 are 3 0 1 2 0 1 3 0, so the order is 1 7 4 2 5 0
        load_config(16'hC61C);
        pulse_lines(8'hB7);
        repeat (6) serve_next();
        expect_reg(reg_pending, 32'd0, "pending");
        end_test("priority_order");

        enable_model = 8'hBF;
        load_config(16'h1000);
        pulse_lines(8'h40);
        repeat (20) begin
            step_cycle();
            check_true(irq === 1'b0, "irq rose for a disabled source");
        end
        expect_reg(reg_pending, 32'h0000_0040, "pending");
        enable_model = '1;
        write_word(reg_enable, 32'h0000_00FF, resp);
        serve_next();
        expect_reg(reg_pending, 32'd0, "pending");
        end_test("enable_mask");

        for (int round = 0; round < 10; round++) begin
            rnd = $random(seed);
            load_config(rnd[prio_flat_w-1:0]);
            rnd = $random(seed);
            mask = (rnd[7:0] == 8'd0) ? 8'h01 : rnd[7:0];
            current_context = $random(seed);
            pulse_lines(mask);
            while (|(pending_model & enable_model)) serve_next();
            expect_reg(reg_pending, 32'd0, "pending");
        end
        end_test("random_rounds");

        $display("Summary: %0d passed, %0d failed, %0d check errors",
                 tests_passed, tests_failed, error_count);
        if (error_count == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule
